//--- design/vid_defs.svh
`ifndef VID_DEFS_SVH
`define VID_DEFS_SVH

//////////////////////////////
// Raster and switch widths
//////////////////////////////
`define VID_COUNT_W 11 // Enough for the 1688-cycle SXGA line
`define VID_SW_W 4 // Format switches

//////////////////////////////
// Switch conditioning
//////////////////////////////
`define VID_SYNC_STAGES 2 // Flops ahead of the debouncer
`define VID_DEBOUNCE_CYCLES 16 // Stable cycles before commit

//////////////////////////////
// Output timing
//////////////////////////////
`define VID_AUX_BURST 32 // Aux enable window length
`define VID_DE_DELAY 2 // Sync and DE lag behind the counters

`endif

//--- design/raster_pkg.sv
`include "vid_defs.svh"

package raster_pkg;

	// One raster count, column or line
	typedef logic [`VID_COUNT_W-1:0] count_t;

	// Current beam position
	typedef struct packed {
		count_t hcount; // Column within the line
		count_t vcount; // Line within the frame
	} raster_pos_t;

endpackage

//--- design/video_fmt_pkg.sv
package video_fmt_pkg;

	import raster_pkg::*;

	// Codes as read from the four switches
	typedef enum logic [3:0] {
		FMT_VGA    = 4'b0000,
		FMT_SVGA   = 4'b0001,
		FMT_HD720P = 4'b0010,
		FMT_XGA    = 4'b0011,
		FMT_SXGA   = 4'b1000,
		FMT_CAMERA = 4'b1001
	} fmt_code_t;

	// Terminal counts of one video mode
	typedef struct packed {
		count_t hsblnk; // Last active column
		count_t hssync; // Last column of front porch
		count_t hesync; // Last column of hsync
		count_t heblnk; // Last column of the line
		count_t vsblnk; // Last active line
		count_t vssync; // Last line of front porch
		count_t vesync; // Last line of vsync
		count_t veblnk; // Last line of the frame
		logic   hv_neg; // 1 for negative sync
	} mode_timing_t;

	// Active length minus one, then porch, pulse and back porch stacked on
	function automatic mode_timing_t build_timing(
		input int   h_act,
		input int   h_fp,
		input int   h_pw,
		input int   h_bp,
		input int   v_act,
		input int   v_fp,
		input int   v_pw,
		input int   v_bp,
		input logic neg
	);
		mode_timing_t t;
		t.hsblnk = count_t'(h_act - 1);
		t.hssync = count_t'(h_act - 1 + h_fp);
		t.hesync = count_t'(h_act - 1 + h_fp + h_pw);
		t.heblnk = count_t'(h_act - 1 + h_fp + h_pw + h_bp);
		t.vsblnk = count_t'(v_act - 1);
		t.vssync = count_t'(v_act - 1 + v_fp);
		t.vesync = count_t'(v_act - 1 + v_fp + v_pw);
		t.veblnk = count_t'(v_act - 1 + v_fp + v_pw + v_bp);
		t.hv_neg = neg;
		return t;
	endfunction

	//////////////////////////////
	// Format table
	//////////////////////////////
	function automatic mode_timing_t mode_timing(input fmt_code_t code);
		mode_timing_t t;
		case (code)
			// 640x480, 800 x 525 total
			FMT_VGA:    t = build_timing(640, 16, 96, 48, 480, 10, 2, 33, 1'b1);
			// 800x600, 1056 x 628 total
			FMT_SVGA:   t = build_timing(800, 40, 128, 88, 600, 1, 4, 23, 1'b0);
			// 1024x768, 1344 x 806 total
			FMT_XGA:    t = build_timing(1024, 24, 136, 160, 768, 3, 6, 29, 1'b1);
			// 1280x1024, 1688 x 1066 total
			FMT_SXGA:   t = build_timing(1280, 48, 112, 248, 1024, 1, 3, 38, 1'b0);
			// Camera flavour of 720p
			FMT_CAMERA: t = build_timing(1280, 110, 39, 220, 720, 4, 4, 22, 1'b0);
			// 720p and any unknown code
			default:    t = build_timing(1280, 110, 40, 220, 720, 5, 5, 20, 1'b0);
		endcase
		return t;
	endfunction

endpackage

//--- design/raster_if.sv
`timescale 1ns/1ps

// Raw raster state, zero lag behind the counters
interface raster_if;

	import raster_pkg::*;

	count_t hcount;    // Column
	count_t vcount;    // Line
	logic   hblnk;     // Past last active column
	logic   vblnk;     // Past last active line
	logic   hsync_raw; // Positive-going hsync
	logic   vsync_raw; // Positive-going vsync

	// Counter side
	modport gen (
		output hcount, vcount, hblnk, vblnk, hsync_raw, vsync_raw
	);

	// Pipeline and scheduler side
	modport sink (
		input hcount, vcount, hblnk, vblnk, hsync_raw, vsync_raw
	);

endinterface

//--- design/format_select.sv
`timescale 1ns/1ps
`include "vid_defs.svh"

module format_select (
	input  logic                        clk50m_bufg,
	input  logic                        RSTBTN,
	input  logic [`VID_SW_W-1:0]        sw,
	output video_fmt_pkg::mode_timing_t mode,
	output logic                        restart
);

	import video_fmt_pkg::*;

	localparam int DEB_W = $clog2(`VID_DEBOUNCE_CYCLES);

	logic [`VID_SYNC_STAGES-1:0][`VID_SW_W-1:0] sw_q; // Synchronizer chain
	logic [`VID_SW_W-1:0] sw_sync; // Last stage
	logic [`VID_SW_W-1:0] sw_prev; // Sync value one cycle back
	fmt_code_t            cur_fmt; // Committed code
	logic [DEB_W-1:0]     deb_cnt; // Cycles the new value has held
	logic                 sw_diff;

	assign sw_sync = sw_q[`VID_SYNC_STAGES-1];
	assign sw_diff = (sw_sync != cur_fmt);

	//////////////////////////////
	// Sync, debounce, commit
	//////////////////////////////
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			sw_q    <= '0;
			sw_prev <= '0;
			cur_fmt <= FMT_VGA; // Boot into VGA
			mode    <= mode_timing(FMT_VGA);
			deb_cnt <= '0;
			restart <= 1'b0;
		end else begin
			sw_q    <= {sw_q[`VID_SYNC_STAGES-2:0], sw};
			sw_prev <= sw_sync;
			restart <= 1'b0; // Single-cycle strobe

			if (!sw_diff) begin
				deb_cnt <= '0; // Back on the committed code
			end else if (sw_sync != sw_prev) begin
				deb_cnt <= DEB_W'(1); // Fresh value, first cycle counted
			end else if (deb_cnt == DEB_W'(`VID_DEBOUNCE_CYCLES - 1)) begin
				// Held long enough
				cur_fmt <= fmt_code_t'(sw_sync);
				mode    <= mode_timing(fmt_code_t'(sw_sync)); // Same edge as restart
				restart <= 1'b1;
				deb_cnt <= '0;
			end else begin
				deb_cnt <= deb_cnt + 1'b1;
			end
		end
	end

endmodule

//--- design/raster_timing_gen.sv
`timescale 1ns/1ps

module raster_timing_gen (
	input  logic                        clk50m_bufg,
	input  logic                        RSTBTN,
	input  video_fmt_pkg::mode_timing_t mode,
	input  logic                        restart,
	raster_if.gen                       rst_if
);

	import raster_pkg::*;

	raster_pos_t pos;   // Beam position
	logic        h_end; // Last column of the line
	logic        v_end; // Last line of the frame

	assign h_end = (pos.hcount == mode.heblnk);
	assign v_end = (pos.vcount == mode.veblnk);

	//////////////////////////////
	// Counters
	//////////////////////////////
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN || restart) begin
			pos <= '0; // Top left of the raster
		end else if (h_end) begin
			pos.hcount <= '0;
			// Line steps only at the wrap
			if (v_end) begin
				pos.vcount <= '0;
			end else begin
				pos.vcount <= pos.vcount + 1'b1;
			end
		end else begin
			pos.hcount <= pos.hcount + 1'b1;
		end
	end

	//////////////////////////////
	// Blank and sync decode
	//////////////////////////////
	assign rst_if.hcount = pos.hcount;
	assign rst_if.vcount = pos.vcount;

	assign rst_if.hblnk = (pos.hcount > mode.hsblnk); // Front porch onward
	assign rst_if.vblnk = (pos.vcount > mode.vsblnk);

	// Pulse sits between end of front porch and end of sync
	assign rst_if.hsync_raw = (pos.hcount > mode.hssync) && (pos.hcount <= mode.hesync);
	assign rst_if.vsync_raw = (pos.vcount > mode.vssync) && (pos.vcount <= mode.vesync);

endmodule

//--- design/sync_de_pipe.sv
`timescale 1ns/1ps
`include "vid_defs.svh"

module sync_de_pipe (
	input  logic   clk50m_bufg,
	input  logic   RSTBTN,
	raster_if.sink rst_if,
	input  logic   sync_neg,
	output logic   hsync,
	output logic   vsync,
	output logic   vde
);

	localparam int DLY = `VID_DE_DELAY;

	logic [DLY-1:0] hs_q;   // Hsync delay line
	logic [DLY-1:0] vs_q;   // Vsync delay line
	logic [DLY-1:0] de_q;   // Active delay line
	logic           active; // Inside both active regions

	assign active = !rst_if.hblnk && !rst_if.vblnk;

	// Stage 0 takes the polarity, later stages only shift
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			hs_q <= {DLY{sync_neg}}; // Idle level of current polarity
			vs_q <= {DLY{sync_neg}};
			de_q <= '0;
		end else begin
			hs_q <= {hs_q[DLY-2:0], rst_if.hsync_raw ^ sync_neg};
			vs_q <= {vs_q[DLY-2:0], rst_if.vsync_raw ^ sync_neg};
			de_q <= {de_q[DLY-2:0], active};
		end
	end

	assign hsync = hs_q[DLY-1];
	assign vsync = vs_q[DLY-1];
	assign vde   = de_q[DLY-1];

endmodule

//--- design/aux_window_sched.sv
`timescale 1ns/1ps
`include "vid_defs.svh"

module aux_window_sched (
	input  logic               clk50m_bufg,
	input  logic               RSTBTN,
	raster_if.sink             rst_if,
	input  logic               aux_load,
	input  raster_pkg::count_t aux_hpos,
	output logic               ade
);

	import raster_pkg::*;

	localparam int BURST_W = $clog2(`VID_AUX_BURST);

	count_t             aux_col;   // Armed column
	logic               armed;     // Waiting for the column
	logic [BURST_W-1:0] burst_cnt; // Cycles into the window
	logic               fire;      // Open the window next edge

	// Only in blanking, never on top of an open window
	assign fire = armed && !ade && (rst_if.hblnk || rst_if.vblnk)
		&& (rst_if.hcount == aux_col);

	always_ff @(posedge clk50m_bufg) begin
		if (aux_load) begin
			aux_col <= aux_hpos; // Newer load wins
		end
	end

	//////////////////////////////
	// Window control
	//////////////////////////////
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			armed     <= 1'b0;
			ade       <= 1'b0;
			burst_cnt <= '0;
		end else begin
			if (fire) begin
				ade       <= 1'b1;
				armed     <= 1'b0; // One window per load
				burst_cnt <= '0;
			end else if (ade) begin
				if (burst_cnt == BURST_W'(`VID_AUX_BURST - 1)) begin
					ade       <= 1'b0; // Burst done
					burst_cnt <= '0;
				end else begin
					burst_cnt <= burst_cnt + 1'b1;
				end
			end
			if (aux_load) begin
				armed <= 1'b1; // Rearm even mid-window
			end
		end
	end

endmodule

//--- design/vid_bridge_top.sv
`timescale 1ns/1ps
`include "vid_defs.svh"

module vid_bridge_top (
	input  logic               clk50m_bufg,
	input  logic               RSTBTN,
	input  logic [`VID_SW_W-1:0] sw,
	input  logic               aux_load,
	input  raster_pkg::count_t aux_hpos,
	output raster_pkg::count_t hcount,
	output raster_pkg::count_t vcount,
	output logic               hsync,
	output logic               vsync,
	output logic               vde,
	output logic               ade
);

	import video_fmt_pkg::*;

	mode_timing_t mode;    // Committed mode timing
	logic         restart; // New mode committed

	raster_if raster_bus ();

	//////////////////////////////
	// Format and raster
	//////////////////////////////
	format_select i_format_select (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.sw          (sw),
		.mode        (mode),
		.restart     (restart)
	);

	raster_timing_gen i_raster_timing_gen (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.mode        (mode),
		.restart     (restart),
		.rst_if      (raster_bus.gen)
	);

	//////////////////////////////
	// Outputs
	//////////////////////////////
	sync_de_pipe i_sync_de_pipe (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.rst_if      (raster_bus.sink),
		.sync_neg    (mode.hv_neg), // Polarity from the table entry
		.hsync       (hsync),
		.vsync       (vsync),
		.vde         (vde)
	);

	aux_window_sched i_aux_window_sched (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.rst_if      (raster_bus.sink),
		.aux_load    (aux_load),
		.aux_hpos    (aux_hpos),
		.ade         (ade)
	);

	// Raw counters, no lag
	assign hcount = raster_bus.hcount;
	assign vcount = raster_bus.vcount;

endmodule

//--- tb/tb_tasks.svh
//////////////////////////////
// Compare tasks
//////////////////////////////
task automatic cmp_count(input string name, input count_t got, input count_t exp);
	if (got !== exp) begin
		mismatch_cnt++;
		$display("MISMATCH %s: got %h, expected %h at %0t", name, got, exp, $time);
	end
endtask

task automatic cmp_bit(input string name, input logic got, input logic exp);
	if (got !== exp) begin
		mismatch_cnt++;
		$display("MISMATCH %s: got %h, expected %h at %0t", name, got, exp, $time);
	end
endtask

// Periods in cycles, tagged with the switch code
task automatic cmp_fmt_period(input string name, input fmt_code_t fmt, input int got,
	input int exp);
	if (got != exp) begin
		mismatch_cnt++;
		$display("MISMATCH %s (format %h): got %h, expected %h at %0t",
			name, fmt, got, exp, $time);
	end
endtask

task automatic report_fail(input string what);
	fail_cnt++;
	$display("ERROR: %s at %0t", what, $time);
endtask

//////////////////////////////
// Helpers
//////////////////////////////
// Next sample with hcount back at zero
task automatic wait_line_start();
	int n;
	n = 0;
	@(negedge clk50m_bufg);
	while (hcount != '0 && n < 4096) begin
		@(negedge clk50m_bufg);
		n++;
	end
	if (hcount != '0) begin
		report_fail("hcount never returned to zero");
	end
endtask

// One full line from column zero
task automatic measure_line(output int period, output int hs_low, output int hs_high,
	output int de_high, output count_t hmax);
	wait_line_start();
	period  = 0;
	hs_low  = 0;
	hs_high = 0;
	de_high = 0;
	hmax    = '0;
	do begin
		if (hsync) begin
			hs_high++;
		end else begin
			hs_low++;
		end
		if (vde) de_high++; // Lags by two, still inside the line
		if (hcount > hmax) hmax = hcount;
		period++;
		@(negedge clk50m_bufg);
	end while (hcount != '0 && period < 4096);
endtask

// Drive the switches and let the commit and restart pass
task automatic set_switches(input logic [`VID_SW_W-1:0] code);
	@(posedge clk50m_bufg);
	sw <= code;
	repeat (SETTLE) @(posedge clk50m_bufg);
endtask

//////////////////////////////
// Directed tests
//////////////////////////////
task automatic reset_state();
	@(negedge clk50m_bufg); // First sample after reset
	cmp_bit("vde", vde, 1'b0);
	cmp_bit("ade", ade, 1'b0);
	cmp_bit("hsync", hsync, 1'b1); // VGA idles high
	cmp_bit("vsync", vsync, 1'b1);
	cmp_count("hcount", hcount, count_t'(0));
	cmp_count("vcount", vcount, count_t'(0));
endtask

task automatic vga_line_timing();
	int     period;
	int     hs_low;
	int     hs_high;
	int     de_high;
	count_t hmax;
	measure_line(period, hs_low, hs_high, de_high, hmax);
	cmp_count("hcount max", hmax, count_t'(VGA_LINE - 1));
	cmp_fmt_period("line period", FMT_VGA, period, VGA_LINE);
	cmp_count("hsync low cycles", count_t'(hs_low), count_t'(96));
	cmp_count("vde high cycles", count_t'(de_high), count_t'(640));
endtask

task automatic vga_frame_timing();
	int     n;
	int     cycles;
	int     vs_low;
	int     de_late;
	count_t vmax;
	n = 0;
	do begin
		wait_line_start(); // Step line by line to the top
		n++;
	end while (vcount != '0 && n < VGA_LINES + 2);
	cycles  = 0;
	vs_low  = 0;
	de_late = 0;
	vmax    = '0;
	do begin
		if (!vsync) vs_low++;
		if (vde && vcount >= count_t'(480)) de_late++;
		if (vcount > vmax) vmax = vcount;
		cycles++;
		@(negedge clk50m_bufg);
	end while (!(hcount == '0 && vcount == '0) && cycles < 2 * VGA_LINE * VGA_LINES);
	cmp_count("vcount max", vmax, count_t'(VGA_LINES - 1));
	cmp_fmt_period("frame period", FMT_VGA, cycles, VGA_LINE * VGA_LINES);
	cmp_count("vsync low cycles", count_t'(vs_low), count_t'(2 * VGA_LINE));
	if (de_late != 0) begin
		report_fail("vde was high on a blank line between 480 and 524");
	end
endtask

task automatic format_change();
	int     period;
	int     hs_low;
	int     hs_high;
	int     de_high;
	count_t hmax;
	set_switches(FMT_SVGA);
	measure_line(period, hs_low, hs_high, de_high, hmax);
	cmp_fmt_period("line period", FMT_SVGA, period, SVGA_LINE);
	cmp_count("hsync high cycles", count_t'(hs_high), count_t'(128)); // Positive pulse
	set_switches(4'b0100); // Unlisted, falls back to 720p
	measure_line(period, hs_low, hs_high, de_high, hmax);
	cmp_fmt_period("line period", fmt_code_t'(4'b0100), period, HD_LINE);
endtask

task automatic debounce_glitch();
	int     period;
	int     hs_low;
	int     hs_high;
	int     de_high;
	count_t hmax;
	wait_line_start(); // Known column before the glitch
	@(posedge clk50m_bufg);
	sw <= 4'b0000; // Short glitch towards VGA
	repeat (`VID_DEBOUNCE_CYCLES - 6) @(posedge clk50m_bufg);
	sw <= 4'b0100;
	repeat (SETTLE) @(posedge clk50m_bufg);
	@(negedge clk50m_bufg);
	// No restart, so the column kept counting from zero
	cmp_count("hcount after glitch", hcount,
		count_t'(1 + `VID_DEBOUNCE_CYCLES - 6 + SETTLE));
	measure_line(period, hs_low, hs_high, de_high, hmax);
	cmp_fmt_period("line period", fmt_code_t'(4'b0100), period, HD_LINE);
endtask

task automatic aux_window_once();
	int     bits;
	int     n;
	int     len;
	count_t col;
	set_switches(FMT_VGA);
	take_bits(8, bits);
	col = count_t'(640 + bits % 160); // Somewhere in horizontal blanking
	wait_line_start();
	@(posedge clk50m_bufg);
	aux_load <= 1'b1;
	aux_hpos <= col;
	@(posedge clk50m_bufg);
	aux_load <= 1'b0;
	n = 0;
	@(negedge clk50m_bufg);
	while (hcount != col && n < 2 * VGA_LINE) begin
		@(negedge clk50m_bufg);
		n++;
	end
	if (hcount != col) begin
		report_fail("hcount never reached the loaded aux column");
	end else begin
		cmp_bit("ade at column", ade, 1'b0);
		@(negedge clk50m_bufg);
		cmp_bit("ade after column", ade, 1'b1); // Opens one cycle later
		len = 0;
		while (ade && len < 4 * `VID_AUX_BURST) begin
			len++;
			@(negedge clk50m_bufg);
		end
		cmp_count("ade window cycles", count_t'(len), count_t'(`VID_AUX_BURST));
		// Next pass over the column must stay quiet
		n = 0;
		repeat (2 * VGA_LINE) begin
			@(negedge clk50m_bufg);
			if (ade) n++;
		end
		if (n != 0) begin
			report_fail("ade opened again without a new load");
		end
	end
endtask

//--- tb/tb_vid_bridge.sv
`timescale 1ns/1ps
`include "vid_defs.svh"

module tb_vid_bridge;

	import raster_pkg::*;
	import video_fmt_pkg::*;

	//////////////////////////////
	// Reference timing
	//////////////////////////////
	localparam int CLK_PERIOD = 20; // ns, 50 MHz
	localparam int VGA_LINE   = 640 + 16 + 96 + 48; // 800 cycles
	localparam int VGA_LINES  = 480 + 10 + 2 + 33;  // 525 lines
	localparam int SVGA_LINE  = 800 + 40 + 128 + 88;
	localparam int HD_LINE    = 1280 + 110 + 40 + 220; // 720p
	// Commit delay with slack for the restart edge
	localparam int SETTLE     = 2 * (`VID_SYNC_STAGES + `VID_DEBOUNCE_CYCLES);
	localparam int WATCHDOG_CYCLES = 3 * VGA_LINE * VGA_LINES + 2 * HD_LINE + 20000;

	logic                 clk50m_bufg = 1'b0;
	logic                 RSTBTN;
	logic [`VID_SW_W-1:0] sw;
	logic                 aux_load;
	count_t               aux_hpos;
	count_t               hcount;
	count_t               vcount;
	logic                 hsync;
	logic                 vsync;
	logic                 vde;
	logic                 ade;

	int          mismatch_cnt = 0; // Wrong values
	int          fail_cnt = 0;     // Anything else
	logic [31:0] lfsr_state = 32'hd5c995f6;

	always #(CLK_PERIOD / 2) clk50m_bufg = ~clk50m_bufg;

	vid_bridge_top i_vid_bridge_top (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.sw          (sw),
		.aux_load    (aux_load),
		.aux_hpos    (aux_hpos),
		.hcount      (hcount),
		.vcount      (vcount),
		.hsync       (hsync),
		.vsync       (vsync),
		.vde         (vde),
		.ade         (ade)
	);

	//////////////////////////////
	// Fibonacci LFSR
	//////////////////////////////
	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	// One step per bit, MSB first
	task automatic take_bits(input int n, output int val);
		val = 0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			val = (val << 1) | int'(lfsr_state[0]);
		end
	endtask

	`include "tb_tasks.svh"

	//////////////////////////////
	// Test sequence
	//////////////////////////////
	initial begin
		RSTBTN   <= 1'b1;
		sw       <= 4'b0000; // VGA
		aux_load <= 1'b0;
		aux_hpos <= '0;
		repeat (2) @(posedge clk50m_bufg);
		RSTBTN <= 1'b0;

		reset_state();
		vga_line_timing();
		vga_frame_timing();
		format_change();
		debounce_glitch();
		aux_window_once();

		$display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
		if (mismatch_cnt == 0 && fail_cnt == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// Watchdog, three VGA frames plus two 720p lines and margin
	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		fail_cnt++;
		$display("ERROR: watchdog expired before the tests finished");
		$display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
		$display("Simulation failed");
		$finish;
	end

endmodule

//--- project.f
+incdir+design
+incdir+tb
design/raster_pkg.sv
design/video_fmt_pkg.sv
design/raster_if.sv
design/format_select.sv
design/raster_timing_gen.sv
design/sync_de_pipe.sv
design/aux_window_sched.sv
design/vid_bridge_top.sv
tb/tb_vid_bridge.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the video bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
LOG=sim.log
TOP=tb_vid_bridge

# Compile and link the simulation binary
verilator --binary --timing --timescale 1ns/1ps \
	--top-module "$TOP" -Mdir "$OBJ_DIR" -f project.f
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

# Run, keeping the output for the search below
"./$OBJ_DIR/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation binary exited with status $status"
	exit 1
fi

# The log decides pass or fail
if grep -q "Simulation failed" "$LOG"; then
	echo "Testbench reported failure, see $LOG"
	exit 1
fi

echo "Testbench run passed"
exit 0
